//--- include/sad_settings.svh
`ifndef SAD_SETTINGS_SVH
`define SAD_SETTINGS_SVH

// Pixel memory geometry
`define SAD_ADDR_W 10
`define SAD_MEM_DEPTH 1024
`define SAD_PIXEL_W 8

// Position, size and SAD values
`define SAD_DATA_W 32

// Window is fixed at 4x4, row-major
`define SAD_WIN 4
`define SAD_PIX_CNT 16

// Start strobe to result strobe, in cycles
// 3 address stages, 1 memory stage, 3 reduce stages
`define SAD_LATENCY 7

`endif

//--- rtl/sadPkg.sv
`default_nettype none

`include "sad_settings.svh"

package sadPkg;

   // One word address into either pixel bank
   typedef logic [`SAD_ADDR_W-1:0] addr_t;

   typedef logic [`SAD_PIXEL_W-1:0] pixel_t;

   // Positions, sizes and SAD values
   typedef logic [`SAD_DATA_W-1:0] word_t;

   // Index is row * SAD_WIN + column
   typedef addr_t [`SAD_PIX_CNT-1:0] addrSet_t;
   typedef pixel_t [`SAD_PIX_CNT-1:0] pixelSet_t;

   // Bank picked by the memory write port
   typedef enum logic {
      memSelFrame  = 1'b0,
      memSelTarget = 1'b1
   } memSel_e;

endpackage

`default_nettype wire

//--- rtl/sadIf.sv
`timescale 1ns/10ps
`default_nettype none

`include "sad_settings.svh"

// Address set from the address generator to the pixel memory
interface sadAddrIf;
   logic valid;
   sadPkg::addrSet_t frameAddr;
   sadPkg::addrSet_t targetAddr;
   // Running SAD carried alongside
   sadPkg::word_t acc;

   modport source (
      output valid,
      output frameAddr,
      output targetAddr,
      output acc
   );

   modport sink (
      input valid,
      input frameAddr,
      input targetAddr,
      input acc
   );
endinterface

// Pixel pairs from the pixel memory to the reduce stages
interface sadPixelIf;
   logic valid;
   sadPkg::pixelSet_t framePix;
   sadPkg::pixelSet_t targetPix;
   sadPkg::word_t acc;

   modport source (
      output valid,
      output framePix,
      output targetPix,
      output acc
   );

   modport sink (
      input valid,
      input framePix,
      input targetPix,
      input acc
   );
endinterface

`default_nettype wire

//--- rtl/sadAddrGen.sv
`timescale 1ns/10ps
`default_nettype none

`include "sad_settings.svh"

module sadAddrGen (
   input  logic          Clk,
   input  logic          rstN,
   input  logic          start,
   input  sadPkg::word_t frameBase,
   input  sadPkg::word_t targetBase,
   input  sadPkg::word_t x,
   input  sadPkg::word_t y,
   input  sadPkg::word_t iter,
   input  sadPkg::word_t numRow,
   input  sadPkg::word_t frameRow,
   input  sadPkg::word_t sadIn,
   sadAddrIf.source      addrOut
);

   logic          s1Valid;
   sadPkg::word_t s1FrameBase;
   sadPkg::word_t s1TargetBase;
   sadPkg::word_t s1X;
   sadPkg::word_t s1Y;
   sadPkg::word_t s1FrameRow;
   sadPkg::word_t s1ItRows;
   sadPkg::word_t s1Acc;

   logic          s2Valid;
   sadPkg::word_t s2RowBase;
   sadPkg::word_t s2TargetBase;
   sadPkg::word_t s2FrameRow;
   sadPkg::word_t s2Acc;

   // Full-width frame addresses ahead of truncation
   sadPkg::word_t frameWord [`SAD_PIX_CNT];
   sadPkg::addrSet_t frameNext;
   sadPkg::addrSet_t targetNext;

   // Valid chain
   always_ff @(posedge Clk) begin
      if (!rstN) begin
         s1Valid <= 1'b0;
         s2Valid <= 1'b0;
         addrOut.valid <= 1'b0;
      end else begin
         s1Valid <= start;
         s2Valid <= s1Valid;
         addrOut.valid <= s2Valid;
      end
   end

   // Stage 1 captures the request, with iter * numRow
   always_ff @(posedge Clk) begin
      s1FrameBase  <= frameBase;
      s1TargetBase <= targetBase;
      s1X          <= x;
      s1Y          <= y;
      s1FrameRow   <= frameRow;
      s1ItRows     <= iter * numRow;
      s1Acc        <= sadIn;
   end

   // Stage 2 gives the address of the window's top-left pixel
   always_ff @(posedge Clk) begin
      s2RowBase    <= (s1Y + s1ItRows) * s1FrameRow + s1FrameBase + s1X;
      s2TargetBase <= s1TargetBase;
      s2FrameRow   <= s1FrameRow;
      s2Acc        <= s1Acc;
   end

   // Row and column offsets for the whole window
   always_comb begin
      for (int r = 0; r < `SAD_WIN; r++) begin
         for (int c = 0; c < `SAD_WIN; c++) begin
            frameWord[r*`SAD_WIN+c] = s2RowBase + sadPkg::word_t'(r) * s2FrameRow
                                      + sadPkg::word_t'(c);
            frameNext[r*`SAD_WIN+c] = sadPkg::addr_t'(frameWord[r*`SAD_WIN+c]);
            // Target window is stored packed, 4 pixels per row
            targetNext[r*`SAD_WIN+c] = sadPkg::addr_t'(s2TargetBase
                                       + sadPkg::word_t'(r*`SAD_WIN+c));
         end
      end
   end

   // Stage 3
   always_ff @(posedge Clk) begin
      addrOut.frameAddr  <= frameNext;
      addrOut.targetAddr <= targetNext;
      addrOut.acc        <= s2Acc;
   end

   // Bottom-right pixel is the highest address, so the whole window fits the bank
   frameInRange: assert property (
      @(posedge Clk) disable iff (!rstN)
      s2Valid |-> (frameWord[`SAD_PIX_CNT-1] < `SAD_MEM_DEPTH)
   ) else $error("frame window runs past the pixel memory");

endmodule

`default_nettype wire

//--- rtl/pixelMemory.sv
`timescale 1ns/10ps
`default_nettype none

`include "sad_settings.svh"

module pixelMemory (
   input  logic            Clk,
   input  logic            memWrEn,
   input  sadPkg::memSel_e memWrSel,
   input  sadPkg::addr_t   memWrAddr,
   input  sadPkg::pixel_t  memWrData,
   sadAddrIf.sink          addrIn,
   sadPixelIf.source       pixOut
);

   sadPkg::pixel_t frameMem [`SAD_MEM_DEPTH];
   sadPkg::pixel_t targetMem [`SAD_MEM_DEPTH];

   // Single write port shared by both banks
   always_ff @(posedge Clk) begin
      if (memWrEn) begin
         if (memWrSel == sadPkg::memSelTarget) begin
            targetMem[memWrAddr] <= memWrData;
         end else begin
            frameMem[memWrAddr] <= memWrData;
         end
      end
   end

   // 16 read ports per bank, registered
   // a write on the same edge is seen on the next read only
   always_ff @(posedge Clk) begin
      for (int i = 0; i < `SAD_PIX_CNT; i++) begin
         pixOut.framePix[i]  <= frameMem[addrIn.frameAddr[i]];
         pixOut.targetPix[i] <= targetMem[addrIn.targetAddr[i]];
      end
      pixOut.acc <= addrIn.acc;
   end

   // Valid follows the address stage, which is cleared by reset
   always_ff @(posedge Clk) begin
      pixOut.valid <= addrIn.valid;
   end

   // Once the forwarded valid has settled after reset it stays known
   validKnown: assert property (
      @(posedge Clk)
      !$isunknown(pixOut.valid) |=> !$isunknown(pixOut.valid)
   ) else $error("pixel valid is unknown");

endmodule

`default_nettype wire

//--- rtl/sadReduce.sv
`timescale 1ns/10ps
`default_nettype none

`include "sad_settings.svh"

module sadReduce (
   input  logic          Clk,
   input  logic          rstN,
   sadPixelIf.sink       pixIn,
   output logic          resultValid,
   output sadPkg::word_t sadOut
);

   sadPkg::pixelSet_t absNext;
   sadPkg::pixelSet_t s1Abs;
   logic              s1Valid;
   sadPkg::word_t     s1Acc;

   sadPkg::word_t pairSum [`SAD_PIX_CNT/2];
   sadPkg::word_t quadSum [`SAD_PIX_CNT/4];

   logic          s2Valid;
   sadPkg::word_t s2Part [`SAD_PIX_CNT/4];
   sadPkg::word_t s2Acc;

   // Absolute difference of each pixel pair
   always_comb begin
      for (int i = 0; i < `SAD_PIX_CNT; i++) begin
         if (pixIn.framePix[i] >= pixIn.targetPix[i]) begin
            absNext[i] = pixIn.framePix[i] - pixIn.targetPix[i];
         end else begin
            absNext[i] = pixIn.targetPix[i] - pixIn.framePix[i];
         end
      end
   end

   // Two levels of the adder tree, 16 down to 4
   always_comb begin
      for (int i = 0; i < `SAD_PIX_CNT/2; i++) begin
         pairSum[i] = sadPkg::word_t'(s1Abs[2*i]) + sadPkg::word_t'(s1Abs[2*i+1]);
      end
      for (int j = 0; j < `SAD_PIX_CNT/4; j++) begin
         quadSum[j] = pairSum[2*j] + pairSum[2*j+1];
      end
   end

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         s1Valid     <= 1'b0;
         s2Valid     <= 1'b0;
         resultValid <= 1'b0;
      end else begin
         s1Valid     <= pixIn.valid;
         s2Valid     <= s1Valid;
         resultValid <= s2Valid;
      end
   end

   always_ff @(posedge Clk) begin
      // Stage 1
      s1Abs <= absNext;
      s1Acc <= pixIn.acc;
      // Stage 2
      s2Part <= quadSum;
      s2Acc  <= s1Acc;
      // Stage 3 closes the tree and adds the running SAD
      sadOut <= s2Part[0] + s2Part[1] + s2Part[2] + s2Part[3] + s2Acc;
   end

   resultTiming: assert property (
      @(posedge Clk) disable iff (!rstN)
      resultValid |-> $past(pixIn.valid, 3)
   ) else $error("result strobe without a pixel set three cycles earlier");

endmodule

`default_nettype wire

//--- rtl/sadEngine.sv
`timescale 1ns/10ps
`default_nettype none

`include "sad_settings.svh"

module sadEngine (
   input  logic            Clk,
   input  logic            rstN,
   input  logic            start,
   input  sadPkg::word_t   frameBase,
   input  sadPkg::word_t   targetBase,
   input  sadPkg::word_t   x,
   input  sadPkg::word_t   y,
   input  sadPkg::word_t   iter,
   input  sadPkg::word_t   numRow,
   input  sadPkg::word_t   frameRow,
   input  sadPkg::word_t   sadIn,
   input  logic            memWrEn,
   input  sadPkg::memSel_e memWrSel,
   input  sadPkg::addr_t   memWrAddr,
   input  sadPkg::pixel_t  memWrData,
   output logic            resultValid,
   output sadPkg::word_t   sadOut
);

   sadAddrIf  addrBus ();
   sadPixelIf pixBus ();

   // Search position to 32 pixel addresses
   sadAddrGen uAddrGen (
      .Clk        (Clk),
      .rstN       (rstN),
      .start      (start),
      .frameBase  (frameBase),
      .targetBase (targetBase),
      .x          (x),
      .y          (y),
      .iter       (iter),
      .numRow     (numRow),
      .frameRow   (frameRow),
      .sadIn      (sadIn),
      .addrOut    (addrBus.source)
   );

   pixelMemory uPixelMemory (
      .Clk       (Clk),
      .memWrEn   (memWrEn),
      .memWrSel  (memWrSel),
      .memWrAddr (memWrAddr),
      .memWrData (memWrData),
      .addrIn    (addrBus.sink),
      .pixOut    (pixBus.source)
   );

   // Differences, adder tree and accumulate
   sadReduce uSadReduce (
      .Clk         (Clk),
      .rstN        (rstN),
      .pixIn       (pixBus.sink),
      .resultValid (resultValid),
      .sadOut      (sadOut)
   );

endmodule

`default_nettype wire

//--- dv/clkGen.sv
`timescale 1ns/10ps
`default_nettype none

// Free-running clock and power-on reset for the testbench
module clkGen (
   output logic Clk,
   output logic rstN
);

   localparam int halfPeriodNs = 20;
   localparam int resetCycles  = 8;

   initial begin
      Clk = 1'b0;
      forever #(halfPeriodNs) Clk = ~Clk;
   end

   // Released on a rising edge, so the DUT sees a clean synchronous deassert
   initial begin
      rstN = 1'b0;
      repeat (resetCycles) @(posedge Clk);
      rstN <= 1'b1;
   end

endmodule

`default_nettype wire

//--- dv/sadTb.sv
`timescale 1ns/10ps
`default_nettype none

`include "sad_settings.svh"

module sadTb;

   localparam int clkPeriodNs = 40;
   localparam int resetCycles = 8;
   localparam int numStarts   = 13;
   localparam int extraWrites = `SAD_PIX_CNT + 2;
   // Reset, bank fill, later writes, every start with its drain, final idle, margin
   localparam int watchdogCycles = resetCycles + 2 * `SAD_MEM_DEPTH + extraWrites
                                   + numStarts * (`SAD_LATENCY + 4) + 2 * `SAD_LATENCY + 100;

   localparam sadPkg::word_t rowsPerIter = 32'd4;
   localparam sadPkg::word_t frameRowLen = 32'd32;

   typedef struct {
      sadPkg::word_t fBase;
      sadPkg::word_t tBase;
      sadPkg::word_t xPos;
      sadPkg::word_t yPos;
      sadPkg::word_t it;
      sadPkg::word_t sIn;
   } request_t;

   typedef struct {
      sadPkg::word_t sad;
      int unsigned   dueEdge;
   } expEntry_t;

   logic            Clk;
   logic            rstN;
   logic            start;
   sadPkg::word_t   frameBase;
   sadPkg::word_t   targetBase;
   sadPkg::word_t   x;
   sadPkg::word_t   y;
   sadPkg::word_t   iter;
   sadPkg::word_t   numRow;
   sadPkg::word_t   frameRow;
   sadPkg::word_t   sadIn;
   logic            memWrEn;
   sadPkg::memSel_e memWrSel;
   sadPkg::addr_t   memWrAddr;
   sadPkg::pixel_t  memWrData;
   logic            resultValid;
   sadPkg::word_t   sadOut;

   // Testbench copy of both pixel banks
   sadPkg::pixel_t frameModel [`SAD_MEM_DEPTH];
   sadPkg::pixel_t targetModel [`SAD_MEM_DEPTH];

   expEntry_t     expQ [$];
   int unsigned   edgeCnt = 0;
   int unsigned   startCnt = 0;
   int unsigned   checkedCnt = 0;
   logic [31:0]   rngState = 32'h3f314894;

   clkGen uClkGen (
      .Clk  (Clk),
      .rstN (rstN)
   );

   sadEngine u_dut (
      .Clk         (Clk),
      .rstN        (rstN),
      .start       (start),
      .frameBase   (frameBase),
      .targetBase  (targetBase),
      .x           (x),
      .y           (y),
      .iter        (iter),
      .numRow      (numRow),
      .frameRow    (frameRow),
      .sadIn       (sadIn),
      .memWrEn     (memWrEn),
      .memWrSel    (memWrSel),
      .memWrAddr   (memWrAddr),
      .memWrData   (memWrData),
      .resultValid (resultValid),
      .sadOut      (sadOut)
   );

   function automatic logic [31:0] nextXorshift(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic sadPkg::word_t randomWord();
      rngState = nextXorshift(rngState);
      return rngState;
   endfunction

   function automatic sadPkg::word_t randomBelow(input sadPkg::word_t n);
      return randomWord() % n;
   endfunction

   // Keeps the whole frame window inside the bank for rows of 32 pixels
   function automatic request_t randomRequest();
      request_t q;
      q.fBase = randomBelow(64);
      q.tBase = randomBelow(`SAD_MEM_DEPTH);
      q.xPos  = randomBelow(28);
      q.yPos  = randomBelow(8);
      q.it    = randomBelow(4);
      q.sIn   = '0;
      return q;
   endfunction

   function automatic sadPkg::addr_t frameAddrOf(input request_t q, input int r, input int c);
      sadPkg::word_t full;
      full = q.fBase + (q.yPos + q.it * rowsPerIter + sadPkg::word_t'(r)) * frameRowLen
             + q.xPos + sadPkg::word_t'(c);
      return sadPkg::addr_t'(full % `SAD_MEM_DEPTH);
   endfunction

   function automatic sadPkg::addr_t targetAddrOf(input request_t q, input int r, input int c);
      sadPkg::word_t full;
      full = q.tBase + sadPkg::word_t'(`SAD_WIN * r + c);
      return sadPkg::addr_t'(full % `SAD_MEM_DEPTH);
   endfunction

   // Expected sadOut from the bank copies
   function automatic sadPkg::word_t refSad(input request_t q);
      sadPkg::word_t total;
      int diff;
      total = q.sIn;
      for (int r = 0; r < `SAD_WIN; r++) begin
         for (int c = 0; c < `SAD_WIN; c++) begin
            diff = int'(frameModel[frameAddrOf(q, r, c)])
                   - int'(targetModel[targetAddrOf(q, r, c)]);
            if (diff < 0) begin
               diff = -diff;
            end
            total = total + sadPkg::word_t'(diff);
         end
      end
      return total;
   endfunction

   task automatic stopWithFailure(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic writePixel(input sadPkg::memSel_e sel, input sadPkg::addr_t addr,
                             input sadPkg::pixel_t data);
      @(posedge Clk);
      start     <= 1'b0;
      memWrEn   <= 1'b1;
      memWrSel  <= sel;
      memWrAddr <= addr;
      memWrData <= data;
      if (sel == sadPkg::memSelTarget) begin
         targetModel[addr] = data;
      end else begin
         frameModel[addr] = data;
      end
   endtask

   // Start rises at this edge, the result strobe follows LATENCY edges later
   task automatic issueStart(input request_t q, input sadPkg::word_t expected);
      @(posedge Clk);
      memWrEn    <= 1'b0;
      start      <= 1'b1;
      frameBase  <= q.fBase;
      targetBase <= q.tBase;
      x          <= q.xPos;
      y          <= q.yPos;
      iter       <= q.it;
      numRow     <= rowsPerIter;
      frameRow   <= frameRowLen;
      sadIn      <= q.sIn;
      expQ.push_back('{sad: expected, dueEdge: edgeCnt + 1 + `SAD_LATENCY});
      startCnt++;
   endtask

   task automatic releaseStrobes();
      @(posedge Clk);
      start   <= 1'b0;
      memWrEn <= 1'b0;
   endtask

   task automatic waitDrain();
      while (expQ.size() != 0) begin
         @(posedge Clk);
      end
   endtask

   always @(posedge Clk) begin
      edgeCnt <= edgeCnt + 1;
   end

   // Outputs are sampled mid-cycle, away from the DUT's updates
   always @(negedge Clk) begin
      expEntry_t head;
      if (edgeCnt > 0) begin
         if (resultValid === 1'b1) begin
            assert (expQ.size() != 0)
               else stopWithFailure("resultValid was high with no start outstanding");
            head = expQ.pop_front();
            assert (head.dueEdge == edgeCnt)
               else stopWithFailure("a result arrived at the wrong cycle");
            assert (sadOut === head.sad)
               else stopWithFailure($sformatf("** Error at %0t ns: sadOut expected %08h, actual %08h",
                                              $time, head.sad, sadOut));
            checkedCnt++;
         end else begin
            assert (resultValid === 1'b0)
               else stopWithFailure("resultValid is unknown");
            if (expQ.size() != 0) begin
               assert (expQ[0].dueEdge != edgeCnt)
                  else stopWithFailure("an expected result did not arrive");
            end
         end
      end
   end

   initial begin
      #(watchdogCycles * clkPeriodNs);
      stopWithFailure("watchdog expired before the tests finished");
   end

   initial begin
      request_t req;
      sadPkg::word_t expB;
      sadPkg::addr_t hitAddr;
      start      <= 1'b0;
      frameBase  <= '0;
      targetBase <= '0;
      x          <= '0;
      y          <= '0;
      iter       <= '0;
      numRow     <= '0;
      frameRow   <= '0;
      sadIn      <= '0;
      memWrEn    <= 1'b0;
      memWrSel   <= sadPkg::memSelFrame;
      memWrAddr  <= '0;
      memWrData  <= '0;
      wait (rstN === 1'b1);

      // Fill both banks, the checker watches for stray results meanwhile
      for (int i = 0; i < `SAD_MEM_DEPTH; i++) begin
         writePixel(sadPkg::memSelFrame, sadPkg::addr_t'(i), sadPkg::pixel_t'(randomWord()));
         writePixel(sadPkg::memSelTarget, sadPkg::addr_t'(i), sadPkg::pixel_t'(randomWord()));
      end
      releaseStrobes();

      // Single start, then accumulation including wraparound
      req = randomRequest();
      issueStart(req, refSad(req));
      releaseStrobes();
      waitDrain();
      req = randomRequest();
      req.sIn = randomWord() | 32'd1;
      issueStart(req, refSad(req));
      releaseStrobes();
      waitDrain();
      req = randomRequest();
      req.sIn = 32'hffff_ff00;
      issueStart(req, refSad(req));
      releaseStrobes();
      waitDrain();

      // Back-to-back burst with distinct positions
      for (int k = 0; k < 6; k++) begin
         req = randomRequest();
         req.xPos = sadPkg::word_t'(4 * k) + randomBelow(4);
         req.yPos = sadPkg::word_t'(k);
         req.it   = sadPkg::word_t'(k % 4);
         req.sIn  = randomWord();
         issueStart(req, refSad(req));
      end
      releaseStrobes();
      waitDrain();

      // Target window copied from the frame window, so the sum is zero
      req = randomRequest();
      for (int r = 0; r < `SAD_WIN; r++) begin
         for (int c = 0; c < `SAD_WIN; c++) begin
            writePixel(sadPkg::memSelTarget, targetAddrOf(req, r, c),
                       frameModel[frameAddrOf(req, r, c)]);
         end
      end
      releaseStrobes();
      req.sIn = randomWord();
      issueStart(req, req.sIn);
      releaseStrobes();
      waitDrain();

      // Frame window at 0..99, target window at 512..527
      req = '{fBase: 0, tBase: 512, xPos: 0, yPos: 0, it: 0, sIn: 32'h100};
      hitAddr = sadPkg::addr_t'(517);
      issueStart(req, refSad(req));
      releaseStrobes();
      waitDrain();
      writePixel(sadPkg::memSelTarget, hitAddr, targetModel[hitAddr] ^ 8'h80);
      releaseStrobes();
      expB = refSad(req);
      issueStart(req, expB);
      releaseStrobes();
      waitDrain();
      // Same address in the frame bank lies outside the frame window
      writePixel(sadPkg::memSelFrame, hitAddr, frameModel[hitAddr] ^ 8'hff);
      releaseStrobes();
      issueStart(req, expB);
      releaseStrobes();
      waitDrain();

      repeat (2 * `SAD_LATENCY) @(posedge Clk);
      if (expQ.size() == 0 && checkedCnt == startCnt) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         stopWithFailure("not every start produced a result");
      end
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
rtl/sadPkg.sv
rtl/sadIf.sv
rtl/sadAddrGen.sv
rtl/pixelMemory.sv
rtl/sadReduce.sv
rtl/sadEngine.sv
dv/clkGen.sv
dv/sadTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = sadTb
FLIST     = flist.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
